// ==== design/arb_pkg.sv ====
// Arbitration constants for a fixed four-requester port; NUM_REQ must be at least 2
package arb_pkg;

  // ----------------------------------------------------------
  // Requester count and derived widths
  // ----------------------------------------------------------

  // Number of requesters that share the single output port
  localparam int unsigned NUM_REQ = 4;

  // Width of a binary requester index as carried on out_src
  localparam int unsigned REQ_IDX_W = $clog2(NUM_REQ);

  // Number of requester pairs in the strict upper triangle of the
  // priority matrix, which is the number of priority flip-flops
  localparam int unsigned NUM_PAIRS = NUM_REQ * (NUM_REQ - 1) / 2;

  // ----------------------------------------------------------
  // The lower triangle and the diagonal of the matrix carry no
  // state of their own, so only NUM_PAIRS bits are stored
  // ----------------------------------------------------------

endpackage : arb_pkg

// ==== design/cmd_pkg.sv ====
// Command payload definition; the word is opaque to the port and carries no parity or tag
package cmd_pkg;

  // ----------------------------------------------------------
  // Command word
  // ----------------------------------------------------------

  // Width of one command word as posted by a requester
  localparam int unsigned CMD_W = 16;

  // One command payload as held in a slot and forwarded on out_data
  // The port never looks inside the word
  typedef logic [CMD_W-1:0] cmd_word_t;

  // ----------------------------------------------------------
  // Every requester and the output port carry this same type
  // ----------------------------------------------------------

endpackage : cmd_pkg

// ==== design/req_slot.sv ====
// One-entry request slot; posts while full are dropped without any indication to the poster
`timescale 1ns/100ps

module req_slot
  import cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      post,
  input  cmd_word_t post_data,
  input  logic      granted,
  output logic      pending,
  output cmd_word_t held_data
);

  // ----------------------------------------------------------
  // Capture condition
  // ----------------------------------------------------------

  // A post is taken only into an empty slot
  // In the cycle of a grant the slot still reads as pending, so a post
  // arriving together with the grant is dropped as well
  logic accept;

  assign accept = post & ~pending;

  // ----------------------------------------------------------
  // Pending flag
  // ----------------------------------------------------------

  // Set one cycle after an accepted post and cleared on the edge that
  // ends the grant cycle
  // The flag is the slot's request to the arbiter and its busy level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (granted) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Held word
  // ----------------------------------------------------------

  // Loaded only on acceptance, so a dropped post leaves it untouched
  // Its contents only matter while pending is high
  always_ff @(posedge clk) begin
    if (accept) begin
      held_data <= post_data;
    end
  end

endmodule : req_slot

// ==== design/lru_arb.sv ====
// LRU matrix arbiter for NUM_REQ requesters; grant is combinational and never registered here
`timescale 1ns/100ps

module lru_arb
  import arb_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable,
  input  logic [NUM_REQ-1:0] request,
  output logic [NUM_REQ-1:0] grant
);

  // ----------------------------------------------------------
  // Priority state
  // ----------------------------------------------------------

  // A set bit prio[i][j] means requester i was used less recently
  // than requester j, so i beats j when both are requesting
  // Only the strict upper triangle lives in flip-flops
  logic [NUM_PAIRS-1:0] state_q;
  logic [NUM_PAIRS-1:0] state_d;

  // Full matrix, rebuilt from the stored triangle every cycle
  logic [NUM_REQ-1:0][NUM_REQ-1:0] prio;

  // Per requester, no active requester ahead of it in the order
  logic [NUM_REQ-1:0] can_grant;

  // Maps an upper-triangle pair (i < j) onto its bit in state_q
  // Rows are packed one after another, row i holding NUM_REQ-1-i bits
  function automatic int unsigned pair_idx(input int unsigned i, input int unsigned j);
    pair_idx = i * NUM_REQ - (i * (i + 1)) / 2 + (j - i - 1);
  endfunction

  // ----------------------------------------------------------
  // Matrix expansion
  // ----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = 0; j < NUM_REQ; j++) begin
        if (i < j) begin
          prio[i][j] = state_q[pair_idx(i, j)];
        end else if (i > j) begin
          // The lower triangle is the complement of its mirror bit
          prio[i][j] = ~state_q[pair_idx(j, i)];
        end else begin
          // A requester never blocks itself, so the diagonal reads as a win
          prio[i][j] = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Grant search
  // ----------------------------------------------------------

  // Requester i may win only if every other requester is idle or
  // ranks behind it; all rows are searched in parallel
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      can_grant[i] = 1'b1;
      for (int j = 0; j < NUM_REQ; j++) begin
        can_grant[i] &= ~request[j] | prio[i][j];
      end
    end
  end

  // The matrix is a total order, so at most one bit survives here
  // With enable low nothing is granted and the state below holds
  assign grant = {NUM_REQ{enable}} & request & can_grant;

  // ----------------------------------------------------------
  // State update
  // ----------------------------------------------------------

  // The winner becomes most recently used
  // Its row is cleared, so it loses to everyone
  // Its column is set, so everyone beats it
  always_comb begin
    state_d = state_q;
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = i + 1; j < NUM_REQ; j++) begin
        if (grant[i]) begin
          state_d[pair_idx(i, j)] = 1'b0;
        end else if (grant[j]) begin
          state_d[pair_idx(i, j)] = 1'b1;
        end
      end
    end
  end

  // Reset to all ones, so the lower index wins every tie at first
  // The order only moves on a cycle that actually grants
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= '1;
    end else if (|grant) begin
      state_q <= state_d;
    end
  end

endmodule : lru_arb

// ==== design/grant_out_reg.sv ====
// Output stage for a one-hot grant; out_valid is a bare pulse and the consumer cannot stall it
`timescale 1ns/100ps

module grant_out_reg
  import arb_pkg::*;
  import cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_REQ-1:0]   grant,
  input  cmd_word_t [NUM_REQ-1:0] slot_data,
  output logic                 out_valid,
  output cmd_word_t            out_data,
  output logic [REQ_IDX_W-1:0] out_src
);

  // ----------------------------------------------------------
  // Grant decode and word select
  // ----------------------------------------------------------

  // Any bit set means a word leaves this cycle
  logic                 any_grant;
  logic [REQ_IDX_W-1:0] sel_idx;
  cmd_word_t            sel_data;

  assign any_grant = |grant;

  // The grant is one-hot or zero, so OR-ing the index of every set bit
  // gives the binary source index without a priority chain
  // The word is picked the same way with an AND-OR mux
  always_comb begin
    sel_idx  = '0;
    sel_data = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      sel_idx  |= REQ_IDX_W'(i) & {REQ_IDX_W{grant[i]}};
      sel_data |= slot_data[i] & {CMD_W{grant[i]}};
    end
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------

  // out_valid follows the grant by exactly one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= any_grant;
    end
  end

  // Word and index load only on a grant and hold in between, so
  // out_data stays on the last forwarded word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_data <= '0;
      out_src  <= '0;
    end else if (any_grant) begin
      out_data <= sel_data;
      out_src  <= sel_idx;
    end
  end

endmodule : grant_out_reg

// ==== design/shared_port_top.sv ====
// Shared output port for NUM_REQ requesters; no flow control, every out_valid must be consumed
`timescale 1ns/100ps

module shared_port_top
  import arb_pkg::*;
  import cmd_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable,
  input  logic [NUM_REQ-1:0]      post,
  input  cmd_word_t [NUM_REQ-1:0] post_data,
  output logic [NUM_REQ-1:0]      busy,
  output logic                    out_valid,
  output cmd_word_t               out_data,
  output logic [REQ_IDX_W-1:0]    out_src
);

  // ----------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------

  // One pending bit per slot, which is both the arbiter request and
  // the busy level seen outside
  logic [NUM_REQ-1:0] request;

  // One-hot or zero grant from the arbiter, valid in the same cycle
  logic [NUM_REQ-1:0] grant;

  // Word currently held in each slot
  cmd_word_t [NUM_REQ-1:0] held_data;

  assign busy = request;

  // ----------------------------------------------------------
  // Request slots
  // ----------------------------------------------------------

  // Each slot clears itself on the edge that ends its grant cycle
  for (genvar g = 0; g < NUM_REQ; g++) begin : gen_slot
    req_slot i_req_slot (
      .clk       (clk),
      .rst_n     (rst_n),
      .post      (post[g]),
      .post_data (post_data[g]),
      .granted   (grant[g]),
      .pending   (request[g]),
      .held_data (held_data[g])
    );
  end

  // ----------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------

  // Picks the least recently served pending slot while enable is high
  lru_arb i_lru_arb (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .request (request),
    .grant   (grant)
  );

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  // Registers the granted word with its source index
  // A post at edge E leaves at edge E+2 at best
  grant_out_reg i_grant_out_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .slot_data (held_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_src   (out_src)
  );

endmodule : shared_port_top

// ==== test/tb_clock_gen.sv ====
// Free-running 100 ns clock; reset is held low for 8 rising edges and released on a falling edge
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD_NS clk = ~clk;
  end

  // Release on the falling edge so the first active edge sees a settled reset
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

// ==== test/shared_port_checker.sv ====
// Bound into shared_port_top; all properties are disabled while rst_n is low
`timescale 1ns/100ps

module shared_port_checker
  import arb_pkg::*;
  import cmd_pkg::*;
(
  input logic               clk,
  input logic               rst_n,
  input logic               enable,
  input logic [NUM_REQ-1:0] busy,
  input logic [NUM_REQ-1:0] request,
  input logic [NUM_REQ-1:0] grant,
  input logic               out_valid
);

  // Failure tally that the testbench reads for its verdict
  int fail_count = 0;

  // ----------------------------------------------------------
  // Output port properties
  // ----------------------------------------------------------

  // A word can only leave if grants were permitted in the cycle before
  a_valid_needs_enable : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(enable)
  ) else begin
    $error("out_valid without enable in the previous cycle");
    fail_count++;
  end

  // Something must have been held for a word to come out
  a_valid_needs_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(busy != '0)
  ) else begin
    $error("out_valid rose while no slot was busy");
    fail_count++;
  end

  // ----------------------------------------------------------
  // Arbiter properties
  // ----------------------------------------------------------

  a_grant_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(grant)
  ) else begin
    $error("grant has more than one bit set");
    fail_count++;
  end

  // A slot that is not pending is never granted
  a_grant_subset : assert property (
    @(posedge clk) disable iff (!rst_n)
    (grant & ~request) == '0
  ) else begin
    $error("grant given to a slot that is not requesting");
    fail_count++;
  end

endmodule : shared_port_checker

bind shared_port_top shared_port_checker i_shared_port_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .enable    (enable),
  .busy      (busy),
  .request   (request),
  .grant     (grant),
  .out_valid (out_valid)
);

// ==== test/shared_port_tb.sv ====
// Inputs change on the falling edge; the LRU model assumes the lower index wins ties after reset
`timescale 1ns/100ps

module shared_port_tb
  import arb_pkg::*;
  import cmd_pkg::*;
();

  // Tests take about 600 cycles; the limit leaves ample headroom
  localparam int TEST_CYCLES    = 600;
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 + 200;

  logic                    clk;
  logic                    rst_n;
  logic                    enable;
  logic [NUM_REQ-1:0]      post;
  cmd_word_t [NUM_REQ-1:0] post_data;
  logic [NUM_REQ-1:0]      busy;
  logic                    out_valid;
  cmd_word_t               out_data;
  logic [REQ_IDX_W-1:0]    out_src;

  // Reference model; m_prio[i][j] set means i was used less recently than j
  logic [NUM_REQ-1:0]              m_busy;
  cmd_word_t [NUM_REQ-1:0]         m_data;
  logic [NUM_REQ-1:0][NUM_REQ-1:0] m_prio;
  logic                            m_valid;
  cmd_word_t                       m_out_data;
  logic [REQ_IDX_W-1:0]            m_out_src;

  logic [REQ_IDX_W-1:0] src_log[$];
  int seed = 32'h300e34ad;
  int cycles = 0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

  shared_port_top i_shared_port_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .post      (post),
    .post_data (post_data),
    .busy      (busy),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_src   (out_src)
  );

  // ----------------------------------------------------------
  // Checking and model helpers
  // ----------------------------------------------------------

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h at cycle %0d", name, exp, act, cycles);
      errors++;
    end
  endtask

  function automatic cmd_word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[CMD_W-1:0];
  endfunction

  // Everything idle, and the order 0, 1, 2, 3 from least to most recent
  task automatic model_reset();
    m_busy     = '0;
    m_data     = '0;
    m_valid    = 1'b0;
    m_out_data = '0;
    m_out_src  = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = 0; j < NUM_REQ; j++) begin
        m_prio[i][j] = (i < j);
      end
    end
  endtask

  // A requester wins when it beats every other active requester
  function automatic logic [NUM_REQ-1:0] lru_winner(input logic [NUM_REQ-1:0] req);
    logic [NUM_REQ-1:0] win;
    logic               beats_all;
    win = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      beats_all = req[i];
      for (int j = 0; j < NUM_REQ; j++) begin
        if (j != i && req[j] && !m_prio[i][j]) begin
          beats_all = 1'b0;
        end
      end
      win[i] = beats_all;
    end
    return win;
  endfunction

  // Advances the model over one edge with the inputs set now, then
  // compares the DUT at the following falling edge
  task automatic step();
    logic [NUM_REQ-1:0] win;
    win = enable ? lru_winner(m_busy) : '0;
    m_valid = |win;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (win[i]) begin
        m_out_data = m_data[i];
        m_out_src  = REQ_IDX_W'(i);
        m_busy[i]  = 1'b0;
        // The winner drops behind everyone else
        for (int j = 0; j < NUM_REQ; j++) begin
          if (j != i) begin
            m_prio[i][j] = 1'b0;
            m_prio[j][i] = 1'b1;
          end
        end
      end else if (post[i] && !m_busy[i]) begin
        m_busy[i] = 1'b1;
        m_data[i] = post_data[i];
      end
    end
    @(posedge clk);
    @(negedge clk);
    post = '0;
    check_field("busy", 32'(m_busy), 32'(busy));
    check_field("out_valid", 32'(m_valid), 32'(out_valid));
    check_field("out_src", 32'(m_out_src), 32'(out_src));
    check_field("out_data", 32'(m_out_data), 32'(out_data));
    if (out_valid === 1'b1) begin
      src_log.push_back(out_src);
    end
  endtask

  // Lets every held word out with enable high
  task automatic drain();
    int guard;
    enable = 1'b1;
    guard  = 0;
    while (m_busy != '0 && guard < 4 * NUM_REQ) begin
      step();
      guard++;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    int          errs;
    cmd_word_t   word;
    logic [31:0] r;
    enable    = 1'b0;
    post      = '0;
    post_data = '0;
    model_reset();
    @(posedge rst_n);

    errs = errors;
    check_field("busy", 32'h0, 32'(busy));
    check_field("out_valid", 32'h0, 32'(out_valid));
    check_field("out_data", 32'h0, 32'(out_data));
    finish_test("reset_state", errs);

    // Every slot is reposted as soon as it goes idle
    errs   = errors;
    enable = 1'b1;
    src_log.delete();
    repeat (40) begin
      for (int i = 0; i < NUM_REQ; i++) begin
        if (!m_busy[i]) begin
          post[i]      = 1'b1;
          post_data[i] = rand_word();
        end
      end
      step();
    end
    drain();
    assert (src_log.size() >= NUM_REQ) else begin
      $display("lru_order saw fewer grants than there are requesters");
      errors++;
    end
    foreach (src_log[k]) begin
      check_field("out_src", 32'(k % NUM_REQ), 32'(src_log[k]));
    end
    finish_test("lru_order", errs);

    // Best-case latency of two cycles from post to out_valid
    errs         = errors;
    word         = rand_word();
    post[2]      = 1'b1;
    post_data[2] = word;
    step();
    check_field("busy", 32'h4, 32'(busy));
    check_field("out_valid", 32'h0, 32'(out_valid));
    step();
    check_field("out_valid", 32'h1, 32'(out_valid));
    check_field("out_src", 32'h2, 32'(out_src));
    check_field("out_data", 32'(word), 32'(out_data));
    check_field("busy", 32'h0, 32'(busy));
    finish_test("single_post", errs);

    // Slots fill while enable is low and then drain in LRU order
    errs   = errors;
    enable = 1'b0;
    for (int i = 0; i < NUM_REQ; i++) begin
      post[i]      = 1'b1;
      post_data[i] = rand_word();
    end
    repeat (20) step();
    src_log.delete();
    drain();
    assert (src_log.size() == NUM_REQ) else begin
      $display("back_pressure drained %0d words instead of one per slot", src_log.size());
      errors++;
    end
    finish_test("back_pressure", errs);

    // The second post meets a full slot and is dropped
    errs         = errors;
    enable       = 1'b0;
    word         = rand_word();
    post[1]      = 1'b1;
    post_data[1] = word;
    step();
    post[1]      = 1'b1;
    post_data[1] = ~word;
    step();
    drain();
    check_field("out_data", 32'(word), 32'(out_data));
    finish_test("busy_post", errs);

    // Enable high about three cycles in four
    errs = errors;
    repeat (400) begin
      r      = $random(seed);
      enable = (r[1:0] != 2'b00);
      post   = r[NUM_REQ+1:2];
      for (int i = 0; i < NUM_REQ; i++) begin
        post_data[i] = rand_word();
      end
      step();
    end
    drain();
    finish_test("random_traffic", errs);

    $display("tests: %0d passed, %0d failed, %0d value mismatches, %0d assertion failures",
             tests_passed, tests_failed, errors,
             i_shared_port_top.i_shared_port_checker.fail_count);
    if (tests_failed == 0 && errors == 0 &&
        i_shared_port_top.i_shared_port_checker.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : shared_port_tb

// ==== vlog.f ====
design/arb_pkg.sv
design/cmd_pkg.sv
design/req_slot.sv
design/lru_arb.sv
design/grant_out_reg.sv
design/shared_port_top.sv
test/tb_clock_gen.sv
test/shared_port_checker.sv
test/shared_port_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the shared port testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module shared_port_tb \
  -f vlog.f \
  -o shared_port_sim

# The raised error limit lets assertion failures reach the testbench verdict
status=0
./obj_dir/shared_port_sim +verilator+error+limit+1000 > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

if [ "$status" -ne 0 ]; then
  exit "$status"
fi

exit 0
